//--- dv/flag_golden.txt
# w0:en addr flags  w1  w2  w3 | alloc:en addr | read:en addr | retire:en addr
# expected after the edge: read_data {pending,flags}, read_src, retire_flags (hex)
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 00  1 00  00 00 00
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 2f  1 13  00 00 00
1 05 2a  0 00 00  0 00 00  0 00 00  0 00  1 05  1 05  2a 01 00
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 05  1 05  2a 00 2a
0 00 00  1 09 15  0 00 00  0 00 00  0 00  0 00  0 00  2a 00 2a
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 09  0 00  15 00 2a
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 09  1 09  15 00 15
0 00 00  0 00 00  0 00 00  0 00 00  1 0c  1 0c  1 0c  7f 10 00
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 0c  1 0c  7f 00 3f
0 00 00  0 00 00  1 0c 11  0 00 00  0 00  1 0c  1 0c  11 04 3f
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 0c  1 0c  11 00 11
1 10 01  1 11 02  1 12 03  1 13 04  0 00  1 12  1 13  03 04 00
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 10  1 11  01 00 02
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 13  1 12  04 00 03
1 20 3e  1 24 1d  1 28 2c  1 2c 07  0 00  1 2c  1 20  07 08 00
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 20  1 24  3e 00 1d
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 28  1 2c  2c 00 07
0 00 00  0 00 00  0 00 00  1 05 3f  1 2d  1 2d  1 05  7f 10 2a
1 2d 00  0 00 00  0 00 00  0 00 00  0 00  1 05  1 2d  3f 00 3f
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 2d  1 2d  00 00 00
0 00 00  0 00 00  0 00 00  0 00 00  0 00  0 00  0 00  00 00 00
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 0a  1 2a  00 00 00
0 00 00  1 01 21  0 00 00  1 02 12  0 00  1 02  0 00  12 08 00
0 00 00  0 00 00  0 00 00  0 00 00  0 00  1 01  1 02  21 00 12

//--- filelist.f
verilog/flag_cfg_pkg.sv
verilog/flag_types_pkg.sv
verilog/flag_write_stage.sv
verilog/flag_bank.sv
verilog/flag_read_bypass.sv
verilog/flag_regfile.sv
dv/flag_regfile_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module flag_regfile_tb -f filelist.f -o sim_flag_regfile

./obj_dir/sim_flag_regfile 2>&1 | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
  echo "flag_regfile run passed"
else
  echo "flag_regfile run failed"
  exit 1
fi

//--- dv/flag_regfile_tb.sv
`timescale 1ns/100ps

module flag_regfile_tb;
  import flag_cfg_pkg::*;
  import flag_types_pkg::*;

  localparam int NUM_WRITE = NUM_WRITE_DEF;
  localparam int NUM_BANKS = NUM_BANKS_DEF;
  localparam int INIT_TIMEOUT = 200; // cycles
  localparam int MAX_LINES = 1000;
  localparam int FIELDS = 21;
  localparam int FILLER_BASE = 48; // golden lines stay below this

  logic clk;
  logic rst;
  flag_write_t [NUM_WRITE-1:0] wr;
  flag_alloc_t alloc;
  logic read_en;
  logic [ADDR_WIDTH-1:0] read_addr;
  logic retire_en;
  logic [ADDR_WIDTH-1:0] retire_addr;
  flag_entry_t read_data;
  logic [NUM_WRITE:0] read_src;
  logic [FLAG_WIDTH-1:0] retire_flags;
  logic init_done;

  int fld [FIELDS];
  logic [FLAG_WIDTH-1:0] model [DEPTH]; // filler addresses only
  logic [31:0] rng_state;

  flag_regfile #(
    .NUM_WRITE (NUM_WRITE),
    .NUM_BANKS (NUM_BANKS)
  ) flag_regfile_inst (
    .clk          (clk),
    .rst          (rst),
    .wr           (wr),
    .alloc        (alloc),
    .read_en      (read_en),
    .read_addr    (read_addr),
    .retire_en    (retire_en),
    .retire_addr  (retire_addr),
    .read_data    (read_data),
    .read_src     (read_src),
    .retire_flags (retire_flags),
    .init_done    (init_done)
  );

  initial
    clk = 1'b0;

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      stop_on_error($sformatf("FAILED at %0t: %s expected %0h, got %0h",
                              $time, name, expected, actual));
    end
  endtask

  task automatic drive_idle();
    wr = '0;
    alloc = '0;
    read_en = 1'b0;
    read_addr = '0;
    retire_en = 1'b0;
    retire_addr = '0;
  endtask

  // 3 columns per write port, then alloc, read and retire
  task automatic drive_line();
    for (int p = 0; p < NUM_WRITE; p++)
    begin
      wr[p].en = fld[3*p] != 0;
      wr[p].addr = ADDR_WIDTH'(fld[3*p+1]);
      wr[p].flags = FLAG_WIDTH'(fld[3*p+2]);
    end
    alloc.en = fld[12] != 0;
    alloc.addr = ADDR_WIDTH'(fld[13]);
    read_en = fld[14] != 0;
    read_addr = ADDR_WIDTH'(fld[15]);
    retire_en = fld[16] != 0;
    retire_addr = ADDR_WIDTH'(fld[17]);
  endtask

  // one random write to the upper addresses on the first free port
  task automatic add_filler();
    int port;
    logic [ADDR_WIDTH-1:0] addr;
    port = -1;
    for (int p = NUM_WRITE - 1; p >= 0; p--)
      if (!wr[p].en)
        port = p;
    if (port >= 0)
    begin
      rng_state = xorshift(rng_state);
      addr = ADDR_WIDTH'(FILLER_BASE + int'(rng_state[3:0]));
      wr[port].en = 1'b1;
      wr[port].addr = addr;
      wr[port].flags = rng_state[4 +: FLAG_WIDTH];
      model[addr] = rng_state[4 +: FLAG_WIDTH];
    end
  endtask

  initial
  begin
    int fd;
    int count;
    int lines;
    int waited;
    string text;
    rst = 1'b1;
    drive_idle();
    rng_state = 32'd35865;
    for (int a = 0; a < DEPTH; a++)
      model[a] = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    expect_equal("init_done", 32'd0, 32'(init_done));

    waited = 0;
    while (!init_done && waited < INIT_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!init_done)
      stop_on_error($sformatf("init_done did not rise within %0d cycles", INIT_TIMEOUT));
    assert (waited >= DEPTH / NUM_BANKS)
    else
    begin
      stop_on_error($sformatf("init_done rose after %0d cycles, too early to clear every row",
                              waited));
    end

    fd = $fopen("dv/flag_golden.txt", "r");
    if (fd == 0)
      stop_on_error("the golden file dv/flag_golden.txt could not be opened");
    lines = 0;
    while (!$feof(fd) && lines < MAX_LINES)
    begin
      text = "";
      count = $fgets(text, fd);
      if (text.len() > 1 && text.getc(0) != "#")
      begin
        count = $sscanf(text,
          "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
          fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
          fld[14], fld[15], fld[16], fld[17], fld[18], fld[19], fld[20]);
        if (count != FIELDS)
          stop_on_error($sformatf("golden line after %0d operations is malformed", lines));
        drive_line();
        add_filler();
        @(negedge clk);
        expect_equal("read_data", 32'(fld[18]), 32'(read_data));
        expect_equal("read_src", 32'(fld[19]), 32'(read_src));
        expect_equal("retire_flags", 32'(fld[20]), 32'(retire_flags));
        expect_equal("init_done", 32'd1, 32'(init_done));
        lines++;
      end
    end
    $fclose(fd);
    if (lines == 0)
      stop_on_error("the golden file held no operations");

    // last random writes land on the first of these edges
    drive_idle();
    for (int a = FILLER_BASE; a < DEPTH; a++)
    begin
      read_en = 1'b1;
      read_addr = ADDR_WIDTH'(a);
      retire_en = 1'b1;
      retire_addr = ADDR_WIDTH'(a);
      @(negedge clk);
      expect_equal("read_data", 32'({1'b0, model[a]}), 32'(read_data));
      expect_equal("read_src", 32'd0, 32'(read_src));
      expect_equal("retire_flags", 32'(model[a]), 32'(retire_flags));
    end
    drive_idle();
    @(negedge clk);

    $display("%0d golden operations and %0d filler reads checked", lines, DEPTH - FILLER_BASE);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- verilog/flag_regfile.sv
`timescale 1ns/100ps

module flag_regfile #(
  parameter int NUM_WRITE = flag_cfg_pkg::NUM_WRITE_DEF,
  parameter int NUM_BANKS = flag_cfg_pkg::NUM_BANKS_DEF
) (
  input  logic                                        clk,
  input  logic                                        rst,
  input  flag_types_pkg::flag_write_t  [NUM_WRITE-1:0] wr,
  input  flag_types_pkg::flag_alloc_t                  alloc,
  input  logic                                        read_en,
  input  logic [flag_cfg_pkg::ADDR_WIDTH-1:0]         read_addr,
  input  logic                                        retire_en,
  input  logic [flag_cfg_pkg::ADDR_WIDTH-1:0]         retire_addr,
  output flag_types_pkg::flag_entry_t                  read_data,
  output logic [NUM_WRITE:0]                          read_src,
  output logic [flag_cfg_pkg::FLAG_WIDTH-1:0]         retire_flags,
  output logic                                        init_done
);
  import flag_cfg_pkg::*;
  import flag_types_pkg::*;

  flag_staged_t [NUM_WRITE:0] staged;
  flag_entry_t [NUM_BANKS-1:0] bank_read;
  logic [NUM_BANKS-1:0][FLAG_WIDTH-1:0] bank_retire;

  flag_write_stage #(
    .NUM_WRITE (NUM_WRITE),
    .NUM_BANKS (NUM_BANKS)
  ) stage_inst (
    .clk       (clk),
    .rst       (rst),
    .wr        (wr),
    .alloc     (alloc),
    .staged    (staged),
    .init_done (init_done)
  );

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    flag_bank #(
      .NUM_WRITE  (NUM_WRITE),
      .NUM_BANKS  (NUM_BANKS),
      .BANK_INDEX (b)
    ) bank_inst (
      .clk          (clk),
      .rst          (rst),
      .staged       (staged),
      .read_en      (read_en),
      .read_addr    (read_addr),
      .retire_en    (retire_en),
      .retire_addr  (retire_addr),
      .read_entry   (bank_read[b]),
      .retire_flags (bank_retire[b])
    );
  end

  flag_read_bypass #(
    .NUM_WRITE (NUM_WRITE),
    .NUM_BANKS (NUM_BANKS)
  ) bypass_inst (
    .clk          (clk),
    .rst          (rst),
    .read_en      (read_en),
    .read_addr    (read_addr),
    .retire_en    (retire_en),
    .retire_addr  (retire_addr),
    .staged       (staged),
    .bank_read    (bank_read),
    .bank_retire  (bank_retire),
    .read_data    (read_data),
    .read_src     (read_src),
    .retire_flags (retire_flags)
  );

endmodule

//--- verilog/flag_read_bypass.sv
`timescale 1ns/100ps

module flag_read_bypass #(
  parameter int NUM_WRITE = flag_cfg_pkg::NUM_WRITE_DEF,
  parameter int NUM_BANKS = flag_cfg_pkg::NUM_BANKS_DEF
) (
  input  logic                                                clk,
  input  logic                                                rst,
  input  logic                                                read_en,
  input  logic [flag_cfg_pkg::ADDR_WIDTH-1:0]                 read_addr,
  input  logic                                                retire_en,
  input  logic [flag_cfg_pkg::ADDR_WIDTH-1:0]                 retire_addr,
  input  flag_types_pkg::flag_staged_t [NUM_WRITE:0]          staged,
  input  flag_types_pkg::flag_entry_t  [NUM_BANKS-1:0]        bank_read,
  input  logic [NUM_BANKS-1:0][flag_cfg_pkg::FLAG_WIDTH-1:0]  bank_retire,
  output flag_types_pkg::flag_entry_t                         read_data,
  output logic [NUM_WRITE:0]                                  read_src,
  output logic [flag_cfg_pkg::FLAG_WIDTH-1:0]                 retire_flags
);
  import flag_cfg_pkg::*;
  import flag_types_pkg::*;

  localparam int BANK_BITS = $clog2(NUM_BANKS);

  logic [NUM_BANKS-1:0] read_sel;
  logic [NUM_BANKS-1:0] retire_sel;
  logic [ADDR_WIDTH-1:0] read_addr_q;
  logic read_fresh;
  logic retire_fresh;
  logic [NUM_WRITE:0] hit;
  logic [NUM_WRITE:0] held_src;
  flag_entry_t live_data;
  flag_entry_t held_data;
  logic [FLAG_WIDTH-1:0] live_retire;
  logic [FLAG_WIDTH-1:0] held_retire;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      read_sel <= '0;
      retire_sel <= '0;
      read_fresh <= 1'b0;
      retire_fresh <= 1'b0;
      held_src <= '0;
    end
    else
    begin
      read_fresh <= read_en;
      retire_fresh <= retire_en;
      if (read_en)
        read_sel <= NUM_BANKS'(1) << read_addr[BANK_BITS-1:0];
      if (retire_en)
        retire_sel <= NUM_BANKS'(1) << retire_addr[BANK_BITS-1:0];
      if (read_fresh)
        held_src <= hit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (read_en)
      read_addr_q <= read_addr;
    if (read_fresh)
      held_data <= live_data;
    if (retire_fresh)
      held_retire <= live_retire;
  end

  always_comb
  begin
    live_data = '0;
    live_retire = '0;
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      if (read_sel[b])
        live_data = bank_read[b];
      if (retire_sel[b])
        live_retire = bank_retire[b];
    end
    // staged write not yet in the bank wins
    for (int s = 0; s <= NUM_WRITE; s++)
    begin
      hit[s] = staged[s].en && (staged[s].addr == read_addr_q);
      if (hit[s])
        live_data = staged[s].entry;
    end
  end

  assign read_data = read_fresh ? live_data : held_data;
  assign read_src = read_fresh ? hit : held_src;
  assign retire_flags = retire_fresh ? live_retire : held_retire; // committed only

  // relies on the stage never staging two writes to one address
  src_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(read_src))
    else $error("read_src has more than one bit set");

endmodule

//--- verilog/flag_bank.sv
`timescale 1ns/100ps

module flag_bank #(
  parameter int NUM_WRITE = flag_cfg_pkg::NUM_WRITE_DEF,
  parameter int NUM_BANKS = flag_cfg_pkg::NUM_BANKS_DEF,
  parameter int BANK_INDEX = 0
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  flag_types_pkg::flag_staged_t [NUM_WRITE:0] staged,
  input  logic                                       read_en,
  input  logic [flag_cfg_pkg::ADDR_WIDTH-1:0]        read_addr,
  input  logic                                       retire_en,
  input  logic [flag_cfg_pkg::ADDR_WIDTH-1:0]        retire_addr,
  output flag_types_pkg::flag_entry_t                read_entry,
  output logic [flag_cfg_pkg::FLAG_WIDTH-1:0]        retire_flags
);
  import flag_cfg_pkg::*;
  import flag_types_pkg::*;

  localparam int BANK_BITS = $clog2(NUM_BANKS);
  localparam int ROWS = DEPTH / NUM_BANKS;
  localparam int ROW_BITS = ADDR_WIDTH - BANK_BITS;

  flag_entry_t mem [ROWS];
  logic [ROW_BITS-1:0] read_row;
  logic [ROW_BITS-1:0] retire_row;
  logic [NUM_WRITE:0] hit;
  logic row_clash;

  function automatic logic in_bank(input logic [ADDR_WIDTH-1:0] addr);
    return addr[BANK_BITS-1:0] == BANK_BITS'(BANK_INDEX);
  endfunction

  always_comb
  begin
    row_clash = 1'b0;
    for (int s = 0; s <= NUM_WRITE; s++)
      hit[s] = staged[s].en && in_bank(staged[s].addr);
    for (int s = 0; s <= NUM_WRITE; s++)
      for (int t = s + 1; t <= NUM_WRITE; t++)
        if (hit[s] && hit[t] && (staged[s].addr == staged[t].addr))
          row_clash = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    for (int s = 0; s <= NUM_WRITE; s++)
      if (hit[s])
        mem[staged[s].addr[ADDR_WIDTH-1:BANK_BITS]] <= staged[s].entry;
  end

  // row only moves when the strobe lands in this bank
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      read_row <= '0;
      retire_row <= '0;
    end
    else
    begin
      if (read_en && in_bank(read_addr))
        read_row <= read_addr[ADDR_WIDTH-1:BANK_BITS];
      if (retire_en && in_bank(retire_addr))
        retire_row <= retire_addr[ADDR_WIDTH-1:BANK_BITS];
    end
  end

  assign read_entry = mem[read_row]; // write-first so last edge's write shows
  assign retire_flags = mem[retire_row].flags;

  // init sweep included and must spread over the banks
  no_row_clash: assert property (@(posedge clk) disable iff (rst) !row_clash)
    else $error("two staged writes to one row of bank %0d", BANK_INDEX);

endmodule

//--- verilog/flag_write_stage.sv
`timescale 1ns/100ps

module flag_write_stage #(
  parameter int NUM_WRITE = flag_cfg_pkg::NUM_WRITE_DEF,
  parameter int NUM_BANKS = flag_cfg_pkg::NUM_BANKS_DEF
) (
  input  logic                                        clk,
  input  logic                                        rst,
  input  flag_types_pkg::flag_write_t  [NUM_WRITE-1:0] wr,
  input  flag_types_pkg::flag_alloc_t                  alloc,
  output flag_types_pkg::flag_staged_t [NUM_WRITE:0]   staged,
  output logic                                        init_done
);
  import flag_cfg_pkg::*;
  import flag_types_pkg::*;

  localparam int BANK_BITS = $clog2(NUM_BANKS);
  localparam int ROW_BITS = ADDR_WIDTH - BANK_BITS;

  flag_staged_t [NUM_WRITE:0] req;
  flag_staged_t [NUM_WRITE:0] next_staged;
  logic [ROW_BITS-1:0] init_row;
  logic init_busy;
  logic addr_clash;
  logic any_req;

  always_comb
  begin
    for (int i = 0; i < NUM_WRITE; i++)
    begin
      req[i].en = wr[i].en;
      req[i].addr = wr[i].addr;
      req[i].entry = {1'b0, wr[i].flags}; // result clears pending
    end
    req[NUM_WRITE].en = alloc.en;
    req[NUM_WRITE].addr = alloc.addr;
    req[NUM_WRITE].entry = '1;
  end

  // sweep takes over the low slots for one row of every bank per cycle
  always_comb
  begin
    next_staged = req;
    if (init_busy)
    begin
      for (int b = 0; b < NUM_BANKS; b++)
      begin
        next_staged[b].en = 1'b1;
        next_staged[b].addr = {init_row, BANK_BITS'(b)};
        next_staged[b].entry = '0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    staged <= next_staged;
    if (rst)
    begin
      for (int s = 0; s <= NUM_WRITE; s++)
        staged[s].en <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      init_busy <= 1'b1;
      init_row <= '0;
      init_done <= 1'b0;
    end
    else
    begin
      if (init_busy)
        init_row <= init_row + 1'b1;
      if (init_busy && (init_row == '1))
        init_busy <= 1'b0;
      init_done <= ~init_busy; // one cycle after the last clear is staged
    end
  end

  always_comb
  begin
    addr_clash = 1'b0;
    any_req = 1'b0;
    for (int i = 0; i <= NUM_WRITE; i++)
    begin
      any_req = any_req | req[i].en;
      for (int j = i + 1; j <= NUM_WRITE; j++)
        if (req[i].en && req[j].en && (req[i].addr == req[j].addr))
          addr_clash = 1'b1;
    end
  end

  no_addr_clash: assert property (@(posedge clk) disable iff (rst) !addr_clash)
    else $error("two write requests to one address");

  idle_before_init: assert property (@(posedge clk) disable iff (rst) any_req |-> init_done)
    else $error("write request before init_done");

endmodule

//--- verilog/flag_types_pkg.sv
package flag_types_pkg;

  // pending sits above the flags
  typedef struct packed {
    logic                                 pending;
    logic [flag_cfg_pkg::FLAG_WIDTH-1:0]  flags;
  } flag_entry_t;

  typedef struct packed {
    logic                                 en;
    logic [flag_cfg_pkg::ADDR_WIDTH-1:0]  addr;
    logic [flag_cfg_pkg::FLAG_WIDTH-1:0]  flags;
  } flag_write_t;

  // allocation carries no data and sets the entry to all ones
  typedef struct packed {
    logic                                 en;
    logic [flag_cfg_pkg::ADDR_WIDTH-1:0]  addr;
  } flag_alloc_t;

  typedef struct packed {
    logic                                 en;
    logic [flag_cfg_pkg::ADDR_WIDTH-1:0]  addr;
    flag_entry_t                          entry;
  } flag_staged_t;

endpackage

//--- verilog/flag_cfg_pkg.sv
package flag_cfg_pkg;

  // one flag field without the pending bit
  localparam int FLAG_WIDTH = 6;

  // register address
  localparam int ADDR_WIDTH = 6;

  localparam int DEPTH = 64; // entries in the whole file

  // result ports into the file
  localparam int NUM_WRITE_DEF = 4;

  // banks picked by the low address bits and dividing DEPTH
  localparam int NUM_BANKS_DEF = 4;

endpackage
